/* bench/mio_tx_assertions.sv */
// bound protocol checks on the mio transmit top, mesh pushback and io beat stall
`default_nettype none

module mio_tx_assertions (
   input wire                        clk,
   input wire                        nreset,
   input wire                        access_in,
   input wire                        wait_out,
   input wire                        io_wait,
   input wire mio_pkg::io_word_t     io_packet,
   input wire mio_pkg::byte_valid_t  io_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;                   // summed into the closing line

   // fifo head masked while in reset
   reset_quiet: assert property (@(posedge clk) !nreset |-> io_valid == '0)
      else begin
         $error("io_valid nonzero during reset");
         fail_count++;
      end

   // only the byte valid codes that the folder can make
   legal_valid: assert property (@(posedge clk) disable iff (!nreset)
      io_valid inside {8'h00, 8'h01, 8'h03, 8'h0F, 8'h1F, 8'hFF})
      else begin
         $error("illegal io_valid code %h", io_valid);
         fail_count++;
      end

   // stalled head beat held as is
   stall_hold: assert property (@(posedge clk) disable iff (!nreset)
      (io_wait && io_valid != '0) |=> ($stable(io_packet) && $stable(io_valid)))
      else begin
         $error("head beat changed under io_wait");
         fail_count++;
      end

   no_access_on_wait: assert property (@(posedge clk) disable iff (!nreset)
      wait_out |-> !access_in)
      else begin
         $error("access_in raised while wait_out high");
         fail_count++;
      end

endmodule

`default_nettype wire

/* bench/mio_tx_tb.sv */
// testbench for the mio transmit top with random mesh packets checked against a beat model
`default_nettype none

module mio_tx_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int AW             = 32;
   localparam int PW             = 40 + 2*AW;     // 104-bit packet
   localparam int FIFO_DEPTH     = 16;
   localparam int NUM_PKTS       = 400;
   localparam int RUN_LEN        = 50;            // packets per emode run
   localparam int RST_CYCLES     = 16;
   localparam int TIMEOUT_CYCLES = NUM_PKTS * 3 * 4 + RST_CYCLES;

   logic                 clk;
   logic                 nreset;
   logic                 emode;
   logic                 access_in;
   logic [PW-1:0]        packet_in;
   logic                 io_wait;
   logic                 wait_out;
   mio_pkg::io_word_t    io_packet;
   mio_pkg::byte_valid_t io_valid;

   integer            seed = 32'h5774;
   mio_pkg::tx_beat_t expect_q[$];                // beats in accept order
   int                beat_errors = 0;
   int                wait_errors = 0;
   int                idle_errors = 0;

   mio_tx #(.AW(AW), .FIFO_DEPTH(FIFO_DEPTH)) dut (
      .clk       (clk),
      .nreset    (nreset),
      .emode     (emode),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .io_packet (io_packet),
      .io_valid  (io_valid),
      .io_wait   (io_wait)
   );

   bind mio_tx mio_tx_assertions u_assertions (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                     // 20 ns period
   end

   //############################################################
   //# reference model and compare tasks
   //############################################################

   task automatic queue_packet(input logic mode, input logic [PW-1:0] pkt);
      mio_pkg::tx_beat_t b;
      if (!mode) begin
         b.data = {pkt[72 +: 32], pkt[40 +: 32]}; // srcaddr over data
         case (pkt[2:1])                          // datamode
            2'd0:    b.valid = 8'h01;
            2'd1:    b.valid = 8'h03;
            2'd2:    b.valid = 8'h0F;
            default: b.valid = 8'hFF;
         endcase
         expect_q.push_back(b);
      end
      else begin
         b.data  = pkt[63:0];
         b.valid = 8'hFF;
         expect_q.push_back(b);
         b.data  = {24'h0, pkt[103:64]};          // 40-bit tail slice
         b.valid = 8'h1F;
         expect_q.push_back(b);
      end
   endtask

   task automatic check_beat(input mio_pkg::io_word_t got_data,
                             input mio_pkg::byte_valid_t got_valid);
      mio_pkg::tx_beat_t exp;
      if (expect_q.size() == 0) begin
         $display("** Error at %0t ns: beat %h/%h with no beat expected",
                  $time, got_data, got_valid);
         beat_errors++;
      end
      else begin
         exp = expect_q.pop_front();
         if (got_data !== exp.data || got_valid !== exp.valid) begin
            $display("** Error at %0t ns: beat %h/%h, expected %h/%h",
                     $time, got_data, got_valid, exp.data, exp.valid);
            beat_errors++;
         end
      end
   endtask

   task automatic check_wait(input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: wait_out %b, expected %b", $time, got, exp);
         wait_errors++;
      end
   endtask

   task automatic check_idle(input mio_pkg::byte_valid_t got);
      if (got !== 8'h00) begin
         $display("** Error at %0t ns: io_valid %h with an empty fifo", $time, got);
         idle_errors++;
      end
   endtask

   //############################################################
   //# stimulus driven on the falling edge for the next rise
   //############################################################

   initial begin : stimulus
      logic [127:0] raw;
      logic [31:0]  roll;
      int           sent;
      int           gap;
      int           stall_left;
      int           level;                        // beats inside the fifo
      int           pending;                      // emesh slices still to push
      logic         accept;
      logic         pop;                          // DUT beat leaves at the next rise
      logic         drain;                        // model fifo loses its head

      sent       = 0;
      gap        = 0;
      stall_left = 0;
      level      = 0;
      pending    = 0;
      nreset     = 1'b0;
      emode      = 1'b0;
      access_in  = 1'b0;
      packet_in  = '0;
      io_wait    = 1'b0;
      repeat (RST_CYCLES) @(negedge clk);
      nreset = 1'b1;

      while (sent < NUM_PKTS || level != 0 || pending != 0) begin
         @(negedge clk);
         roll = $random(seed);
         if (stall_left != 0)
            stall_left--;
         else if (roll[7:0] == 8'd0 && sent < NUM_PKTS)
            stall_left = 24;                      // long stall fills the fifo
         io_wait = (stall_left != 0) || (roll[15:8] % 10 < 3);

         access_in = 1'b0;
         if (gap != 0)
            gap--;
         else if (sent < NUM_PKTS && !wait_out) begin
            raw       = {$random(seed), $random(seed), $random(seed), $random(seed)};
            packet_in = raw[PW-1:0];
            emode     = ((sent / RUN_LEN) % 2) == 1;
            access_in = 1'b1;
            gap       = roll[17:16];              // 0..3 idle cycles after
            sent++;
         end

         check_wait(wait_out, (level >= FIFO_DEPTH/2) || (pending != 0));
         if (level == 0)
            check_idle(io_valid);
         accept = access_in && !wait_out;
         pop    = (io_valid != '0) && !io_wait;
         drain  = (level != 0) && !io_wait;
         if (pop)
            check_beat(io_packet, io_valid);
         if (accept)
            queue_packet(emode, packet_in);
         level = level + ((accept || pending != 0) ? 1 : 0) - (drain ? 1 : 0);
         if (pending != 0)
            pending--;
         else if (accept && emode)
            pending = (PW + 63) / 64 - 1;         // slices after the first
      end

      @(negedge clk);
      check_idle(io_valid);                       // fully drained
      if (expect_q.size() != 0) begin
         $display("%0d expected beats never left the DUT", expect_q.size());
         beat_errors++;
      end
      $display("errors: beat %0d, wait %0d, idle %0d, assertion %0d",
               beat_errors, wait_errors, idle_errors, dut.u_assertions.fail_count);
      if (beat_errors + wait_errors + idle_errors + dut.u_assertions.fail_count == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/mio_pkg.sv */
// mio transmit shared types: beats, byte valids, mesh fields, folder state
`default_nettype none

package mio_pkg;

   //############################################################
   //# beat types
   //############################################################

   typedef logic [63:0] io_word_t;     // payload of one io beat
   typedef logic [7:0]  byte_valid_t;  // one flag per byte lane

   // one fifo entry, also the folder output
   typedef struct packed {
      io_word_t    data;   // [71:8]
      byte_valid_t valid;  // [7:0]
   } tx_beat_t;

   // byte valid patterns seen on the io side
   localparam byte_valid_t VALID_BYTE   = 8'h01; // datamode 00
   localparam byte_valid_t VALID_HALF   = 8'h03; // datamode 01
   localparam byte_valid_t VALID_WORD   = 8'h0F; // datamode 10
   localparam byte_valid_t VALID_DOUBLE = 8'hFF; // datamode 11, full slices
   localparam byte_valid_t VALID_TAIL   = 8'h1F; // last emesh slice, 40 bits

   //############################################################
   //# mesh packet fields
   //############################################################

   typedef logic [1:0]  datamode_t;   // transaction size code
   typedef logic [4:0]  ctrlmode_t;   // control mode
   typedef logic [63:0] mesh_addr_t;  // addr/data, zero-extended to widest AW

   // named view of one mesh packet
   typedef struct packed {
      logic       write;
      datamode_t  datamode;
      ctrlmode_t  ctrlmode;
      mesh_addr_t dstaddr;
      mesh_addr_t data;
      mesh_addr_t srcaddr;
   } mesh_fields_t;

   //############################################################
   //# folder state
   //############################################################

   typedef enum logic [1:0] {
      fold_idle,   // waiting for a packet, pushes first beat on accept
      fold_beat1,  // second emesh slice
      fold_beat2   // third slice, AW=64 only
   } fold_state_t;

endpackage

`default_nettype wire

/* logic/mio_tx.sv */
// mio transmit top, unpacks mesh packets, folds them into beats and queues them for io
`default_nettype none

module mio_tx #(
   parameter int AW         = 32,                 // mesh address width, 32 or 64
   parameter int FIFO_DEPTH = 16                  // beat fifo depth, power of two
) (
   input  wire                   clk,
   input  wire                   nreset,          // async, active low
   input  wire                   emode,           // 0 compact, 1 emesh
   // mesh side
   input  wire                   access_in,       // packet strobe
   input  wire  [39+2*AW:0]      packet_in,       // mesh packet
   output logic                  wait_out,        // pushback to mesh
   // io side
   output mio_pkg::io_word_t     io_packet,       // beat payload
   output mio_pkg::byte_valid_t  io_valid,        // byte valids, zero = no beat
   input  wire                   io_wait          // io stall
);

   mio_pkg::mesh_fields_t fields;
   mio_pkg::tx_beat_t     beat;
   logic                  beat_push;
   logic                  fifo_wait;

   //############################################################
   //# mesh side
   //############################################################

   mtx_packet_decode #(.AW(AW)) u_decode (
      .packet_in (packet_in),
      .fields    (fields)
   );

   mtx_beat_fold #(.AW(AW)) u_fold (
      .clk       (clk),
      .nreset    (nreset),
      .emode     (emode),
      .access_in (access_in),
      .packet_in (packet_in),                     // raw slices in emesh mode
      .fields    (fields),
      .fifo_wait (fifo_wait),
      .wait_out  (wait_out),
      .beat_push (beat_push),
      .beat      (beat)
   );

   //############################################################
   //# io side
   //############################################################

   mtx_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .beat_push (beat_push),
      .beat      (beat),
      .io_wait   (io_wait),
      .fifo_wait (fifo_wait),
      .io_packet (io_packet),
      .io_valid  (io_valid)
   );

endmodule

`default_nettype wire

/* logic/mtx_beat_fold.sv */
// beat folder, turns an accepted mesh packet into one to three 64-bit io beats
`default_nettype none

module mtx_beat_fold #(
   parameter int AW = 32                          // mesh address width
) (
   input  wire                          clk,
   input  wire                          nreset,     // async, active low
   input  wire                          emode,      // 1 = send raw packet slices
   input  wire                          access_in,  // packet strobe from mesh
   input  wire  [39+2*AW:0]             packet_in,  // raw packet, for emesh slicing
   input  wire  mio_pkg::mesh_fields_t  fields,     // unpacked packet
   input  wire                          fifo_wait,  // fifo half full
   output logic                         wait_out,   // pushback to mesh
   output logic                         beat_push,  // fifo write strobe
   output mio_pkg::tx_beat_t            beat        // fifo write entry
);

   localparam int PW    = 40 + 2*AW;              // packet width
   localparam int BUF_W = 192;                    // three full slices

   mio_pkg::fold_state_t state;
   mio_pkg::fold_state_t state_nxt;
   mio_pkg::tx_beat_t    compact_beat;
   logic [BUF_W-1:0]     pkt_buf;                 // packet held for later slices
   logic                 accept;

   //############################################################
   //# handshake
   //############################################################

   // busy folding, or fifo already half full
   assign wait_out = fifo_wait | (state != mio_pkg::fold_idle);
   assign accept   = access_in & ~wait_out;

   //############################################################
   //# compact beat
   //############################################################

   always_comb begin
      compact_beat.data = {fields.srcaddr[31:0], fields.data[31:0]}; // src over data
      case (fields.datamode)
         2'b00:   compact_beat.valid = mio_pkg::VALID_BYTE;
         2'b01:   compact_beat.valid = mio_pkg::VALID_HALF;
         2'b10:   compact_beat.valid = mio_pkg::VALID_WORD;
         default: compact_beat.valid = mio_pkg::VALID_DOUBLE;
      endcase
   end

   //############################################################
   //# fold state machine
   //############################################################

   always_comb begin
      state_nxt = state;
      case (state)
         mio_pkg::fold_idle:
            if (accept && emode)
               state_nxt = mio_pkg::fold_beat1;   // more slices to go
         mio_pkg::fold_beat1:
            state_nxt = (AW == 64) ? mio_pkg::fold_beat2 : mio_pkg::fold_idle;
         mio_pkg::fold_beat2:
            state_nxt = mio_pkg::fold_idle;
         default:
            state_nxt = mio_pkg::fold_idle;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         state <= mio_pkg::fold_idle;
      else
         state <= state_nxt;
   end

   // registered copy, zero padded up to three slices
   always_ff @(posedge clk) begin
      if (accept)
         pkt_buf <= {{(BUF_W-PW){1'b0}}, packet_in};
   end

   //############################################################
   //# beat mux
   //############################################################

   always_comb begin
      beat_push = 1'b0;
      beat      = compact_beat;
      case (state)
         mio_pkg::fold_idle: begin
            beat_push = accept;                   // first beat on the accept edge
            if (emode) begin
               beat.data  = packet_in[63:0];
               beat.valid = mio_pkg::VALID_DOUBLE;
            end
         end
         mio_pkg::fold_beat1: begin
            beat_push  = 1'b1;
            beat.data  = pkt_buf[127:64];
            beat.valid = (AW == 64) ? mio_pkg::VALID_DOUBLE : mio_pkg::VALID_TAIL;
         end
         mio_pkg::fold_beat2: begin
            beat_push  = 1'b1;
            beat.data  = pkt_buf[191:128];        // top 40 bits of a 168-bit packet
            beat.valid = mio_pkg::VALID_TAIL;
         end
         default: beat_push = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/mtx_packet_decode.sv */
// mesh packet unpacker, slices a packet into named fields zero-extended to 64 bits
`default_nettype none

module mtx_packet_decode #(
   parameter int AW = 32                       // mesh address width, 32 or 64
) (
   input  wire  [39+2*AW:0]       packet_in,   // raw mesh packet
   output mio_pkg::mesh_fields_t  fields       // unpacked view
);

   //############################################################
   //# packet layout
   //############################################################

   // header word is 40 bits: 8 control bits plus destination
   localparam int HDR_W    = 8;
   localparam int DST_W    = 32;
   localparam int DATA_LSB = HDR_W + DST_W;    // data right above header word
   localparam int SRC_LSB  = DATA_LSB + AW;    // srcaddr fills the top AW bits

   logic [DST_W-1:0] dst_raw;
   logic [AW-1:0]    data_raw;
   logic [AW-1:0]    src_raw;

   assign dst_raw  = packet_in[HDR_W +: DST_W];
   assign data_raw = packet_in[DATA_LSB +: AW];
   assign src_raw  = packet_in[SRC_LSB +: AW];

   //############################################################
   //# field view
   //############################################################

   always_comb begin
      fields = '0;                              // upper address bits stay zero
      fields.write    = packet_in[0];
      fields.datamode = packet_in[2:1];
      fields.ctrlmode = packet_in[7:3];

      // zero-extend each address/data field
      fields.dstaddr[DST_W-1:0] = dst_raw;
      fields.data[AW-1:0]       = data_raw;
      fields.srcaddr[AW-1:0]    = src_raw;
   end

endmodule

`default_nettype wire

/* logic/mtx_sync_fifo.sv */
// synchronous beat fifo with half-full pushback and the head presented to the io logic
`default_nettype none

module mtx_sync_fifo #(
   parameter int FIFO_DEPTH = 16                  // power-of-two entry count
) (
   input  wire                    clk,
   input  wire                    nreset,         // async active-low reset
   input  wire                    beat_push,      // write strobe from folder
   input  wire  mio_pkg::tx_beat_t beat,          // write entry
   input  wire                    io_wait,        // io stall level
   output logic                   fifo_wait,      // occupancy >= half
   output mio_pkg::io_word_t      io_packet,      // head payload
   output mio_pkg::byte_valid_t   io_valid        // head valids or zero when empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;              // counts up to FIFO_DEPTH

   mio_pkg::tx_beat_t mem [FIFO_DEPTH];
   mio_pkg::tx_beat_t head;
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              empty;
   logic              pop;

   //############################################################
   //# storage
   //############################################################

   // beat storage array
   always_ff @(posedge clk) begin
      if (beat_push)
         mem[wr_ptr] <= beat;
   end

   //############################################################
   //# pointers and occupancy
   //############################################################

   assign empty = (count == '0);
   assign pop   = (|io_valid) & ~io_wait;         // beat leaves this edge

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (beat_push)
            wr_ptr <= wr_ptr + 1'b1;              // wraps at the power-of-two depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({beat_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;              // idle or push with pop
         endcase
      end
   end

   // half full leaves room for another three-beat packet
   assign fifo_wait = (count >= CNT_W'(FIFO_DEPTH/2));

   //############################################################
   //# head
   //############################################################

   assign head      = mem[rd_ptr];
   assign io_packet = head.data;
   assign io_valid  = empty ? '0 : head.valid;    // held while io_wait is high

endmodule

`default_nettype wire

/* mio_tx.f */
logic/mio_pkg.sv
logic/mtx_packet_decode.sv
logic/mtx_beat_fold.sv
logic/mtx_sync_fifo.sv
logic/mio_tx.sv
bench/mio_tx_assertions.sv
bench/mio_tx_tb.sv
